// File: design/ooo_consts.svh
`ifndef OOO_CONSTS_SVH
`define OOO_CONSTS_SVH

// data word width
`define OOO_XLEN      32
// reorder buffer entries, tag width is log2 of this
`define OOO_ROB_DEPTH 8
`define OOO_TAG_W     3
// slots per reservation station
`define OOO_RS_DEPTH  2

`endif

// File: design/ooo_isa_pkg.sv
`include "ooo_consts.svh"

package ooo_isa_pkg;

    typedef logic [4:0] reg_addr_t;

    // alu operations of the register-register and register-immediate forms
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SLT
    } alu_op_t;

    // decoded instruction as handed to dispatch
    typedef struct packed {
        alu_op_t              op;
        reg_addr_t            rd;
        reg_addr_t            rs1;
        reg_addr_t            rs2;
        logic                 use_imm;
        logic [`OOO_XLEN-1:0] imm;
    } instr_t;

endpackage

// File: design/ooo_core_pkg.sv
`include "ooo_consts.svh"

package ooo_core_pkg;

    import ooo_isa_pkg::*;

    // reorder buffer index, doubles as the rename tag
    typedef logic [`OOO_TAG_W-1:0] tag_t;

    // source operand, data is meaningful only once valid is set
    typedef struct packed {
        logic                 valid;
        tag_t                 tag;
        logic [`OOO_XLEN-1:0] data;
    } operand_t;

    // word written into a reservation station slot
    typedef struct packed {
        alu_op_t  op;
        operand_t src1;
        operand_t src2;
        tag_t     rd_tag;
    } res_word_t;

    // one common data bus broadcast
    typedef struct packed {
        logic                 valid;
        tag_t                 tag;
        logic [`OOO_XLEN-1:0] data;
    } cdb_t;

    // one retired result
    typedef struct packed {
        logic                 valid;
        reg_addr_t            rd;
        logic [`OOO_XLEN-1:0] data;
    } commit_t;

endpackage

// File: design/dispatch_fsm.sv
`timescale 1ns/1ps

module dispatch_fsm
    import ooo_isa_pkg::*;
    import ooo_core_pkg::*;
(
    input  logic       clk,
    input  logic       reset_i,
    input  logic       instr_valid_i,
    input  instr_t     instr_i,
    input  logic       rob_full_i,
    input  logic [1:0] rs_free_i,
    input  operand_t   src_lookup_i [2],
    input  tag_t       tail_tag_i,
    output reg_addr_t  rs1_o,
    output reg_addr_t  rs2_o,
    output logic       stall_o,
    output logic       alloc_o,
    output logic [1:0] rs_load_o,
    output res_word_t  res_word_o,
    output reg_addr_t  rd_o
);

    typedef enum logic {
        READY,
        HOLD
    } state_t;

    state_t state_q;
    state_t state_d;
    instr_t held_q;
    logic   held_valid_q;
    logic   room;
    logic   issue;

    // a rob entry and at least one station slot are needed
    assign room  = !rob_full_i && (rs_free_i != 2'b00);
    assign issue = held_valid_q && room;

    assign alloc_o      = issue;
    // station 0 first, station 1 only when 0 is full
    assign rs_load_o[0] = issue && rs_free_i[0];
    assign rs_load_o[1] = issue && !rs_free_i[0];

    // held instruction with no room means the source must wait
    assign stall_o = (state_q == HOLD) || (held_valid_q && !room);

    assign rs1_o = held_q.rs1;
    assign rs2_o = held_q.rs2;
    assign rd_o  = held_q.rd;

    always_comb begin
        state_d = state_q;
        case (state_q)
            READY: begin
                if (held_valid_q && !room) begin
                    state_d = HOLD;
                end
            end
            HOLD: begin
                if (room) begin
                    state_d = READY;
                end
            end
            default: state_d = READY;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q      <= READY;
            held_valid_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (instr_valid_i) begin
                held_valid_q <= 1'b1;
            end else if (issue) begin
                held_valid_q <= 1'b0;
            end
        end
    end

    // hold slot refills in the same cycle the previous one issues
    always_ff @(posedge clk) begin
        if (instr_valid_i) begin
            held_q <= instr_i;
        end
    end

    always_comb begin
        res_word_o.op     = held_q.op;
        res_word_o.src1   = src_lookup_i[0];
        res_word_o.rd_tag = tail_tag_i;
        if (held_q.use_imm) begin
            res_word_o.src2 = '{valid: 1'b1, tag: '0, data: held_q.imm};
        end else begin
            res_word_o.src2 = src_lookup_i[1];
        end
    end

    // the source has to honour stall from the previous cycle
    a_no_strobe_stalled: assert property (
        @(posedge clk) disable iff (reset_i) instr_valid_i |-> !stall_o
    ) else $error("strobe while stall_o is high at %0t", $time);

endmodule : dispatch_fsm

// File: design/rob_ptrs.sv
`timescale 1ns/1ps
`include "ooo_consts.svh"

module rob_ptrs
    import ooo_core_pkg::*;
(
    input  logic clk,
    input  logic reset_i,
    input  logic alloc_i,
    input  logic retire_i,
    output tag_t head_o,
    output tag_t tail_o,
    output logic full_o
);

    tag_t                head_q;
    tag_t                tail_q;
    logic [`OOO_TAG_W:0] count_q;

    assign head_o = head_q;
    assign tail_o = tail_q;
    assign full_o = (count_q == (`OOO_TAG_W+1)'(`OOO_ROB_DEPTH));

    // pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clk) begin
        if (reset_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (alloc_i) begin
                tail_q <= tail_q + 1'b1;
            end
            if (retire_i) begin
                head_q <= head_q + 1'b1;
            end
            case ({alloc_i, retire_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    a_no_alloc_full: assert property (
        @(posedge clk) disable iff (reset_i) (alloc_i && full_o) |-> retire_i
    ) else $error("rob allocation while full at %0t", $time);

endmodule : rob_ptrs

// File: design/rob.sv
`timescale 1ns/1ps
`include "ooo_consts.svh"

module rob
    import ooo_core_pkg::*;
(
    input  logic       clk,
    input  logic       reset_i,
    input  logic       alloc_i,
    input  logic [4:0] rd_i,
    input  cdb_t       cdb_i,
    input  tag_t       lookup_tag_i [2],
    output operand_t   lookup_o [2],
    output tag_t       tail_o,
    output tag_t       head_o,
    output logic       full_o,
    output commit_t    commit_o
);

    logic [4:0]                rd_q   [`OOO_ROB_DEPTH];
    logic [`OOO_XLEN-1:0]      data_q [`OOO_ROB_DEPTH];
    logic [`OOO_ROB_DEPTH-1:0] done_q;
    logic                      retire;

    // free entries always have done clear, so done at the head means retire
    assign retire = done_q[head_o];

    rob_ptrs ptrs (
        .clk      (clk),
        .reset_i  (reset_i),
        .alloc_i  (alloc_i),
        .retire_i (retire),
        .head_o   (head_o),
        .tail_o   (tail_o),
        .full_o   (full_o)
    );

    always_ff @(posedge clk) begin
        if (reset_i) begin
            done_q <= '0;
        end else begin
            if (retire) begin
                done_q[head_o] <= 1'b0;
            end
            if (alloc_i) begin
                done_q[tail_o] <= 1'b0;
            end
            if (cdb_i.valid) begin
                done_q[cdb_i.tag] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_i) begin
            rd_q[tail_o] <= rd_i;
        end
        if (cdb_i.valid) begin
            data_q[cdb_i.tag] <= cdb_i.data;
        end
    end

    assign commit_o = '{valid: retire, rd: rd_q[head_o], data: data_q[head_o]};

    // operand forwarding for tags that finished but have not retired yet
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            lookup_o[i].valid = done_q[lookup_tag_i[i]];
            lookup_o[i].tag   = lookup_tag_i[i];
            lookup_o[i].data  = data_q[lookup_tag_i[i]];
        end
    end

endmodule : rob

// File: design/regfile.sv
`timescale 1ns/1ps
`include "ooo_consts.svh"

module regfile
    import ooo_isa_pkg::*;
    import ooo_core_pkg::*;
(
    input  logic      clk,
    input  logic      reset_i,
    input  reg_addr_t rs1_i,
    input  reg_addr_t rs2_i,
    input  logic      alloc_i,
    input  reg_addr_t alloc_rd_i,
    input  tag_t      alloc_tag_i,
    input  commit_t   commit_i,
    input  tag_t      commit_tag_i,
    output operand_t  src_o [2]
);

    logic [`OOO_XLEN-1:0] regs_q [32];
    tag_t                 tag_q  [32];
    logic [31:0]          busy_q;
    reg_addr_t            rs_sel [2];

    assign rs_sel[0] = rs1_i;
    assign rs_sel[1] = rs2_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            busy_q <= '0;
            for (int i = 0; i < 32; i++) begin
                regs_q[i] <= '0;
                tag_q[i]  <= '0;
            end
        end else begin
            // x0 is never written and never renamed
            if (commit_i.valid && commit_i.rd != 5'd0) begin
                regs_q[commit_i.rd] <= commit_i.data;
                // only the newest owner of the register clears busy
                if (tag_q[commit_i.rd] == commit_tag_i) begin
                    busy_q[commit_i.rd] <= 1'b0;
                end
            end
            // a rename in the same cycle overrides the clear above
            if (alloc_i && alloc_rd_i != 5'd0) begin
                busy_q[alloc_rd_i] <= 1'b1;
                tag_q[alloc_rd_i]  <= alloc_tag_i;
            end
        end
    end

    // busy registers hand out the producing tag instead of a value
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            src_o[i].valid = !busy_q[rs_sel[i]];
            src_o[i].tag   = tag_q[rs_sel[i]];
            src_o[i].data  = regs_q[rs_sel[i]];
        end
    end

endmodule : regfile

// File: design/reservation_station.sv
`timescale 1ns/1ps
`include "ooo_consts.svh"

module reservation_station
    import ooo_isa_pkg::*;
    import ooo_core_pkg::*;
(
    input  logic      clk,
    input  logic      reset_i,
    input  logic      load_i,
    input  res_word_t res_word_i,
    input  cdb_t      cdb_i,
    input  logic      grant_i,
    output logic      free_o,
    output logic      req_o,
    output cdb_t      result_o
);

    localparam int IDX_W = (`OOO_RS_DEPTH > 1) ? $clog2(`OOO_RS_DEPTH) : 1;

    res_word_t                slot_q [`OOO_RS_DEPTH];
    logic [`OOO_RS_DEPTH-1:0] busy_q;
    logic [`OOO_RS_DEPTH-1:0] ready;
    logic [IDX_W-1:0]         free_idx;
    logic [IDX_W-1:0]         sel_idx;
    res_word_t                load_word;
    logic [`OOO_XLEN-1:0]     alu_out;

    // pick up a waiting operand when its tag shows up on the bus
    function automatic operand_t snoop(input operand_t op, input cdb_t bus);
        operand_t res;
        res = op;
        if (!op.valid && bus.valid && bus.tag == op.tag) begin
            res.valid = 1'b1;
            res.data  = bus.data;
        end
        return res;
    endfunction

    function automatic logic [`OOO_XLEN-1:0] alu(
        input alu_op_t              op,
        input logic [`OOO_XLEN-1:0] a,
        input logic [`OOO_XLEN-1:0] b
    );
        logic [`OOO_XLEN-1:0] res;
        case (op)
            ALU_ADD: res = a + b;
            ALU_SUB: res = a - b;
            ALU_AND: res = a & b;
            ALU_OR:  res = a | b;
            ALU_XOR: res = a ^ b;
            ALU_SLL: res = a << b[4:0];
            ALU_SRL: res = a >> b[4:0];
            ALU_SLT: res = {{(`OOO_XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            default: res = a + b;
        endcase
        return res;
    endfunction

    // the incoming word may need the broadcast of this very cycle
    always_comb begin
        load_word      = res_word_i;
        load_word.src1 = snoop(res_word_i.src1, cdb_i);
        load_word.src2 = snoop(res_word_i.src2, cdb_i);
    end

    always_comb begin
        free_idx = '0;
        sel_idx  = '0;
        for (int i = `OOO_RS_DEPTH-1; i >= 0; i--) begin
            ready[i] = busy_q[i] && slot_q[i].src1.valid && slot_q[i].src2.valid;
            if (!busy_q[i]) begin
                free_idx = IDX_W'(i);
            end
            if (ready[i]) begin
                sel_idx = IDX_W'(i);
            end
        end
    end

    assign free_o   = !(&busy_q);
    assign req_o    = |ready;
    assign alu_out  = alu(slot_q[sel_idx].op, slot_q[sel_idx].src1.data,
                          slot_q[sel_idx].src2.data);
    assign result_o = '{valid: req_o, tag: slot_q[sel_idx].rd_tag, data: alu_out};

    always_ff @(posedge clk) begin
        if (reset_i) begin
            busy_q <= '0;
        end else begin
            if (load_i) begin
                busy_q[free_idx] <= 1'b1;
            end
            if (grant_i) begin
                busy_q[sel_idx] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `OOO_RS_DEPTH; i++) begin
            if (load_i && free_idx == IDX_W'(i)) begin
                slot_q[i] <= load_word;
            end else begin
                slot_q[i].src1 <= snoop(slot_q[i].src1, cdb_i);
                slot_q[i].src2 <= snoop(slot_q[i].src2, cdb_i);
            end
        end
    end

    a_load_when_free: assert property (
        @(posedge clk) disable iff (reset_i) load_i |-> free_o
    ) else $error("station load with no free slot at %0t", $time);

endmodule : reservation_station

// File: design/cdb_arbiter.sv
`timescale 1ns/1ps

module cdb_arbiter
    import ooo_core_pkg::*;
(
    input  logic       clk,
    input  logic       reset_i,
    input  logic [1:0] req_i,
    input  cdb_t       result_i [2],
    output logic [1:0] grant_o,
    output cdb_t       cdb_o
);

    cdb_t winner;

    // fixed priority, station 0 wins and station 1 keeps requesting
    assign grant_o[0] = req_i[0];
    assign grant_o[1] = req_i[1] && !req_i[0];
    assign winner     = req_i[0] ? result_i[0] : result_i[1];

    // one registered broadcast per cycle
    always_ff @(posedge clk) begin
        if (reset_i) begin
            cdb_o.valid <= 1'b0;
        end else begin
            cdb_o.valid <= winner.valid && (|req_i);
            if (|req_i) begin
                cdb_o.tag  <= winner.tag;
                cdb_o.data <= winner.data;
            end
        end
    end

endmodule : cdb_arbiter

// File: design/ooo.sv
`timescale 1ns/1ps

module ooo
    import ooo_isa_pkg::*;
    import ooo_core_pkg::*;
(
    input  logic    clk,
    input  logic    reset_i,
    input  logic    instr_valid_i,
    input  instr_t  instr_i,
    output logic    stall_o,
    output commit_t commit_o
);

    logic       alloc;
    logic       rob_full;
    logic [1:0] rs_free;
    logic [1:0] rs_load;
    logic [1:0] rs_req;
    logic [1:0] rs_grant;
    tag_t       tail_tag;
    tag_t       head_tag;
    reg_addr_t  alloc_rd;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    res_word_t  res_word;
    operand_t   rf_src     [2];
    operand_t   rob_src    [2];
    operand_t   src_lookup [2];
    tag_t       lookup_tag [2];
    cdb_t       rs_result  [2];
    cdb_t       cdb;

    // regfile value if not busy, else whatever the rob knows about the tag
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            lookup_tag[i] = rf_src[i].tag;
            src_lookup[i] = rf_src[i].valid ? rf_src[i] : rob_src[i];
        end
    end

    dispatch_fsm dispatch (
        .clk           (clk),
        .reset_i       (reset_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .rob_full_i    (rob_full),
        .rs_free_i     (rs_free),
        .src_lookup_i  (src_lookup),
        .tail_tag_i    (tail_tag),
        .rs1_o         (rs1),
        .rs2_o         (rs2),
        .stall_o       (stall_o),
        .alloc_o       (alloc),
        .rs_load_o     (rs_load),
        .res_word_o    (res_word),
        .rd_o          (alloc_rd)
    );

    rob rob (
        .clk          (clk),
        .reset_i      (reset_i),
        .alloc_i      (alloc),
        .rd_i         (alloc_rd),
        .cdb_i        (cdb),
        .lookup_tag_i (lookup_tag),
        .lookup_o     (rob_src),
        .tail_o       (tail_tag),
        .head_o       (head_tag),
        .full_o       (rob_full),
        .commit_o     (commit_o)
    );

    regfile regfile (
        .clk          (clk),
        .reset_i      (reset_i),
        .rs1_i        (rs1),
        .rs2_i        (rs2),
        .alloc_i      (alloc),
        .alloc_rd_i   (alloc_rd),
        .alloc_tag_i  (tail_tag),
        .commit_i     (commit_o),
        .commit_tag_i (head_tag),
        .src_o        (rf_src)
    );

    for (genvar g = 0; g < 2; g++) begin : g_rs
        reservation_station res (
            .clk        (clk),
            .reset_i    (reset_i),
            .load_i     (rs_load[g]),
            .res_word_i (res_word),
            .cdb_i      (cdb),
            .grant_i    (rs_grant[g]),
            .free_o     (rs_free[g]),
            .req_o      (rs_req[g]),
            .result_o   (rs_result[g])
        );
    end

    cdb_arbiter arbiter (
        .clk      (clk),
        .reset_i  (reset_i),
        .req_i    (rs_req),
        .result_i (rs_result),
        .grant_o  (rs_grant),
        .cdb_o    (cdb)
    );

endmodule : ooo

// File: testbench/tb_ooo.sv
`timescale 1ns/1ps
`include "ooo_consts.svh"

module tb_ooo
    import ooo_isa_pkg::*;
    import ooo_core_pkg::*;
();

    // cycles any single wait may take before the run is abandoned
    localparam int LIMIT = 400;

    logic    clk;
    logic    reset_i;
    logic    instr_valid_i;
    instr_t  instr_i;
    logic    stall_o;
    commit_t commit_o;

    logic [`OOO_XLEN-1:0] model_regs [32];
    commit_t              expected_q [$];
    commit_t              head_exp;
    integer               seed;
    int                   errors;
    int                   checks;
    int                   tests_run;
    int                   test_base;
    int                   commits_seen;
    logic                 stall_seen;
    logic                 timed_out;

    ooo UUT (
        .clk           (clk),
        .reset_i       (reset_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .stall_o       (stall_o),
        .commit_o      (commit_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // reference alu, shift amounts use the low five bits of b
    function automatic logic [`OOO_XLEN-1:0] model_alu(
        input alu_op_t              op,
        input logic [`OOO_XLEN-1:0] a,
        input logic [`OOO_XLEN-1:0] b
    );
        case (op)
            ALU_ADD: return a + b;
            ALU_SUB: return a - b;
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_XOR: return a ^ b;
            ALU_SLL: return a << b[4:0];
            ALU_SRL: return a >> b[4:0];
            default: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        endcase
    endfunction

    function automatic instr_t make_instr(
        input alu_op_t              op,
        input reg_addr_t            rd,
        input reg_addr_t            rs1,
        input reg_addr_t            rs2,
        input logic                 use_imm,
        input logic [`OOO_XLEN-1:0] imm
    );
        instr_t ins;
        ins.op      = op;
        ins.rd      = rd;
        ins.rs1     = rs1;
        ins.rs2     = rs2;
        ins.use_imm = use_imm;
        ins.imm     = imm;
        return ins;
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic finish_run();
        $display("tests run: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    endtask

    // later sends and drains return at once, so the run goes straight to its summary
    task automatic give_up(input string what);
        errors++;
        timed_out = 1'b1;
        $display("timeout at %0t: %s", $time, what);
    endtask

    // waits out stall_o, presents one instruction for one edge and books its commit
    task automatic send(input instr_t ins);
        int                   waited;
        logic [`OOO_XLEN-1:0] b;
        commit_t              c;
        if (timed_out) begin
            return;
        end
        waited = 0;
        while (stall_o && waited < LIMIT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (stall_o) begin
            give_up("stall_o stayed high and no instruction could be sent");
            return;
        end
        instr_valid_i = 1'b1;
        instr_i       = ins;
        b             = ins.use_imm ? ins.imm : model_regs[ins.rs2];
        c.valid       = 1'b1;
        c.rd          = ins.rd;
        c.data        = model_alu(ins.op, model_regs[ins.rs1], b);
        expected_q.push_back(c);
        // x0 keeps reading as zero whatever was computed for it
        if (ins.rd != 5'd0) begin
            model_regs[ins.rd] = c.data;
        end
        @(posedge clk);
        #1;
        instr_valid_i = 1'b0;
    endtask

    task automatic drain();
        int waited;
        if (timed_out) begin
            return;
        end
        waited = 0;
        while (expected_q.size() != 0 && waited < LIMIT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (expected_q.size() != 0) begin
            give_up("outstanding instructions never committed");
        end
    endtask

    task automatic report_test(input string name);
        tests_run++;
        $display("test %0d %s: %0d errors", tests_run, name, errors - test_base);
        test_base = errors;
    endtask

    // commit_o only moves on the rising edge, so the falling edge sees it settled
    always @(negedge clk) begin
        if (stall_o) begin
            stall_seen = 1'b1;
        end
        if (!reset_i && commit_o.valid) begin
            commits_seen++;
            checks++;
            assert (expected_q.size() > 0) else begin
                errors++;
                $display("unexpected commit to x%0d at %0t with nothing outstanding",
                         commit_o.rd, $time);
            end
            if (expected_q.size() > 0) begin
                head_exp = expected_q.pop_front();
                check_value("commit rd", 32'(commit_o.rd), 32'(head_exp.rd));
                check_value("commit data", commit_o.data, head_exp.data);
            end
        end
    end

    initial begin
        int                   burst_start;
        logic [`OOO_XLEN-1:0] imm_a;
        seed          = 32'hb0bc_1f65;
        errors        = 0;
        checks        = 0;
        tests_run     = 0;
        test_base     = 0;
        commits_seen  = 0;
        stall_seen    = 1'b0;
        timed_out     = 1'b0;
        reset_i       = 1'b1;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end
        repeat (3) @(posedge clk);
        #1;
        reset_i = 1'b0;

        @(negedge clk);
        check_value("stall_o after reset", 32'(stall_o), 32'd0);
        check_value("commit valid after reset", 32'(commit_o.valid), 32'd0);
        @(posedge clk);
        #1;
        report_test("reset");

        // seed x1..x4, then every opcode in immediate and register form
        for (int r = 1; r <= 4; r++) begin
            imm_a = $random(seed);
            send(make_instr(ALU_ADD, 5'(r), 5'd0, 5'd0, 1'b1, imm_a));
        end
        for (int k = 0; k < 8; k++) begin
            imm_a = $random(seed);
            send(make_instr(alu_op_t'(k), 5'(10 + k), 5'd1, 5'd0, 1'b1, imm_a));
            send(make_instr(alu_op_t'(k), 5'(18 + k), 5'd2, 5'd3, 1'b0, '0));
        end
        drain();
        report_test("opcodes");

        send(make_instr(ALU_ADD, 5'd26, 5'd1, 5'd0, 1'b1, 32'd7));
        send(make_instr(ALU_SUB, 5'd27, 5'd26, 5'd2, 1'b0, '0));
        send(make_instr(ALU_XOR, 5'd28, 5'd27, 5'd26, 1'b0, '0));
        send(make_instr(ALU_SLL, 5'd29, 5'd28, 5'd0, 1'b1, 32'd3));
        send(make_instr(ALU_SLT, 5'd30, 5'd29, 5'd27, 1'b0, '0));
        // independent work that can finish ahead of the chain
        send(make_instr(ALU_AND, 5'd31, 5'd4, 5'd0, 1'b1, 32'h00ff_00ff));
        send(make_instr(ALU_OR, 5'd9, 5'd3, 5'd4, 1'b0, '0));
        drain();
        report_test("dependency chain");

        // a serial chain on x5 fills the stations and the rob
        burst_start = commits_seen;
        imm_a       = $random(seed);
        send(make_instr(ALU_ADD, 5'd5, 5'd0, 5'd0, 1'b1, imm_a));
        stall_seen = 1'b0;
        for (int n = 0; n < `OOO_ROB_DEPTH + 4; n++) begin
            imm_a = $random(seed);
            send(make_instr(ALU_ADD, 5'd5, 5'd5, 5'd0, 1'b1, imm_a));
        end
        drain();
        check_value("stall seen in burst", 32'(stall_seen), 32'd1);
        check_value("burst commit count", 32'(commits_seen - burst_start),
                    32'(`OOO_ROB_DEPTH + 5));
        report_test("burst");

        imm_a = $random(seed);
        send(make_instr(ALU_ADD, 5'd0, 5'd1, 5'd0, 1'b1, imm_a));
        send(make_instr(ALU_OR, 5'd6, 5'd0, 5'd0, 1'b0, '0));
        send(make_instr(ALU_ADD, 5'd6, 5'd0, 5'd6, 1'b0, '0));
        drain();
        report_test("x0 write");

        send(make_instr(ALU_ADD, 5'd7, 5'd0, 5'd0, 1'b1, 32'h1111_0000));
        send(make_instr(ALU_XOR, 5'd7, 5'd1, 5'd0, 1'b1, 32'h0000_2222));
        send(make_instr(ALU_ADD, 5'd8, 5'd7, 5'd0, 1'b1, 32'd0));
        drain();
        // read again once both renames have retired
        send(make_instr(ALU_OR, 5'd8, 5'd7, 5'd0, 1'b0, '0));
        drain();
        report_test("double rename");

        finish_run();
    end

endmodule : tb_ooo

// File: project.f
+incdir+design
design/ooo_isa_pkg.sv
design/ooo_core_pkg.sv
design/dispatch_fsm.sv
design/rob_ptrs.sv
design/rob.sv
design/regfile.sv
design/reservation_station.sv
design/cdb_arbiter.sv
design/ooo.sv
testbench/tb_ooo.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds tb_ooo with Verilator, runs it and judges the log
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing --assert -f project.f --top-module tb_ooo \
    -Mdir "$BUILD_DIR" -o tb_ooo_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/tb_ooo_sim" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "Finished with errors" "$LOG"; then
    echo "FAIL"
    exit 1
fi
if ! grep -q "Finished with no errors" "$LOG"; then
    echo "no final result line in $LOG"
    exit 1
fi
echo "PASS"
exit 0
